//--- include/io_settings.svh
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// --------------------------------------------------
// device pages
// --------------------------------------------------

`define IO_LEDS_PAGE 24'hFD0FFF // adr[31:8]
`define IO_RST_PAGE 24'hFD0FFC  // adr[31:8]
`define IO_SCR_PAGE 12'h001     // adr[31:20] for the whole region

// scratchpad size in 32-bit words
`define IO_SCR_WORDS 64

// --------------------------------------------------
// node resets
// --------------------------------------------------

`define IO_NODE_COUNT 8
`define RST_HOLD_CYCLES 64 // node_clk cycles a mask stays applied

// --------------------------------------------------
// periodic tick
// --------------------------------------------------

`define TICK_PERIOD 100 // count runs 1 .. TICK_PERIOD
`define TICK_ON 15
`define TICK_OFF 20

`endif

//--- rtl/io_pkg.sv
package io_pkg;

	`include "io_settings.svh"

	// --------------------------------------------------
	// bus words
	// --------------------------------------------------

	typedef logic [31:0] bus_adr_t; // byte address
	typedef logic [31:0] bus_dat_t;
	typedef logic [3:0] bus_sel_t;  // one enable per byte lane

	// --------------------------------------------------
	// device select
	// --------------------------------------------------

	// target picked by the decode stage
	typedef enum logic [1:0] {
		dev_none = 2'd0, // unmapped address
		dev_leds = 2'd1,
		dev_rst = 2'd2,
		dev_scr = 2'd3
	} dev_sel_t;

	// one reset bit per node
	typedef logic [`IO_NODE_COUNT-1:0] node_mask_t;

endpackage

//--- rtl/node_reset_ctrl.sv
`include "io_settings.svh"

module node_reset_ctrl (
	input logic node_clk,
	input logic rst,
	input logic wr_i,
	input io_pkg::node_mask_t mask_i,
	output io_pkg::node_mask_t node_rst_o
);

	import io_pkg::*;

	localparam int unsigned HOLD = `RST_HOLD_CYCLES;
	localparam int unsigned HOLD_W = $clog2(HOLD + 1);

	node_mask_t mask_q;
	logic [HOLD_W-1:0] hold_cnt; // saturates at HOLD
	logic holding;

	assign holding = (hold_cnt < HOLD_W'(HOLD));

	always_ff @(posedge node_clk) begin
		if (rst) begin
			mask_q <= '1; // every node held after system reset
			hold_cnt <= '0;
		end else if (wr_i) begin
			mask_q <= mask_i;
			hold_cnt <= '0; // restart the hold
		end else if (holding) begin
			hold_cnt <= hold_cnt + 1'b1;
		end else begin
			mask_q <= '0; // release once the hold is over
		end
	end

	// mask applies only during the hold window
	assign node_rst_o = holding ? mask_q : '0;

endmodule

//--- rtl/tick_timer.sv
`include "io_settings.svh"

module tick_timer (
	input logic node_clk,
	input logic rst,
	output logic tick_irq_o
);

	localparam int unsigned CNT_W = $clog2(`TICK_PERIOD + 1);

	logic [CNT_W-1:0] tick_cnt;

	// free-running count 1 .. TICK_PERIOD
	always_ff @(posedge node_clk) begin
		if (rst) begin
			tick_cnt <= CNT_W'(1);
			tick_irq_o <= 1'b0;
		end else begin
			if (tick_cnt == CNT_W'(`TICK_PERIOD))
				tick_cnt <= CNT_W'(1); // wrap
			else
				tick_cnt <= tick_cnt + 1'b1;

			if (tick_cnt == CNT_W'(`TICK_ON))
				tick_irq_o <= 1'b1;
			else if (tick_cnt == CNT_W'(`TICK_OFF))
				tick_irq_o <= 1'b0;
		end
	end

endmodule

//--- rtl/io_decode.sv
`include "io_settings.svh"

module io_decode (
	input logic node_clk,
	input logic rst,
	input logic stb_i,
	input logic we_i,
	input io_pkg::bus_sel_t sel_i,
	input io_pkg::bus_adr_t adr_i,
	input io_pkg::bus_dat_t dat_i,
	output logic req_vld_o,
	output io_pkg::dev_sel_t req_dev_o,
	output logic req_we_o,
	output io_pkg::bus_sel_t req_sel_o,
	output logic [5:0] req_word_o,
	output io_pkg::bus_dat_t req_dat_o
);

	import io_pkg::*;

	logic stb_q;     // strobe seen at the previous edge
	logic accept;
	dev_sel_t dev_nxt;

	// master holds stb until the reply, so only the rising edge counts
	assign accept = stb_i & ~stb_q;

	// --------------------------------------------------
	// page decode
	// --------------------------------------------------

	always_comb begin
		if (adr_i[31:8] == `IO_LEDS_PAGE)
			dev_nxt = dev_leds;
		else if (adr_i[31:8] == `IO_RST_PAGE)
			dev_nxt = dev_rst;
		else if (adr_i[31:20] == `IO_SCR_PAGE)
			dev_nxt = dev_scr;
		else
			dev_nxt = dev_none; // answered with a bus error
	end

	// --------------------------------------------------
	// request register
	// --------------------------------------------------

	always_ff @(posedge node_clk) begin
		if (rst) begin
			stb_q <= 1'b0;
			req_vld_o <= 1'b0;
		end else begin
			stb_q <= stb_i;
			req_vld_o <= accept; // single cycle pulse
		end
	end

	// payload qualified by req_vld_o downstream
	always_ff @(posedge node_clk) begin
		if (accept) begin
			req_dev_o <= dev_nxt;
			req_we_o <= we_i;
			req_sel_o <= sel_i;
			req_word_o <= adr_i[7:2]; // word within the page
			req_dat_o <= dat_i;
		end
	end

endmodule

//--- rtl/io_devices.sv
`include "io_settings.svh"

module io_devices (
	input logic node_clk,
	input logic rst,
	input logic req_vld_i,
	input io_pkg::dev_sel_t req_dev_i,
	input logic req_we_i,
	input io_pkg::bus_sel_t req_sel_i,
	input logic [5:0] req_word_i,
	input io_pkg::bus_dat_t req_dat_i,
	output logic rsp_vld_o,
	output logic rsp_hit_o,
	output io_pkg::bus_dat_t rsp_dat_o,
	output logic [7:0] leds_o,
	output io_pkg::node_mask_t node_rst_o
);

	import io_pkg::*;

	bus_dat_t scr_mem [`IO_SCR_WORDS];
	bus_dat_t rd_dat;
	logic leds_wr;
	logic rst_wr;
	logic scr_wr;

	assign leds_wr = req_vld_i & req_we_i & (req_dev_i == dev_leds);
	assign rst_wr = req_vld_i & req_we_i & (req_dev_i == dev_rst);
	assign scr_wr = req_vld_i & req_we_i & (req_dev_i == dev_scr);

	// --------------------------------------------------
	// node reset controller
	// --------------------------------------------------

	node_reset_ctrl u_node_reset_ctrl (
		.node_clk (node_clk),
		.rst (rst),
		.wr_i (rst_wr),
		.mask_i (req_dat_i[`IO_NODE_COUNT-1:0]),
		.node_rst_o (node_rst_o)
	);

	// --------------------------------------------------
	// led register and scratchpad
	// --------------------------------------------------

	always_ff @(posedge node_clk) begin
		if (rst)
			leds_o <= 8'h00;
		else if (leds_wr)
			leds_o <= req_dat_i[7:0]; // byte 0 only
	end

	always_ff @(posedge node_clk) begin
		if (scr_wr) begin
			for (int b = 0; b < 4; b++) begin
				if (req_sel_i[b])
					scr_mem[req_word_i][b*8 +: 8] <= req_dat_i[b*8 +: 8];
			end
		end
	end

	// read mux
	always_comb begin
		case (req_dev_i)
			dev_leds: rd_dat = {24'h000000, leds_o};
			dev_rst: rd_dat = bus_dat_t'(node_rst_o);
			dev_scr: rd_dat = scr_mem[req_word_i];
			default: rd_dat = '0;
		endcase
	end

	// --------------------------------------------------
	// response register
	// --------------------------------------------------

	always_ff @(posedge node_clk) begin
		if (rst)
			rsp_vld_o <= 1'b0;
		else
			rsp_vld_o <= req_vld_i;
	end

	always_ff @(posedge node_clk) begin
		rsp_hit_o <= (req_dev_i != dev_none);
		rsp_dat_o <= req_we_i ? '0 : rd_dat; // writes return zero
	end

endmodule

//--- rtl/io_respond.sv
module io_respond (
	input logic node_clk,
	input logic rst,
	input logic rsp_vld_i,
	input logic rsp_hit_i,
	input io_pkg::bus_dat_t rsp_dat_i,
	output logic ack_o,
	output logic err_o,
	output io_pkg::bus_dat_t dat_o
);

	logic take;

	assign take = rsp_vld_i & rsp_hit_i;

	// --------------------------------------------------
	// reply register
	// --------------------------------------------------

	// devices only send one pulse per request, so ack and err
	// follow as single cycle pulses too
	always_ff @(posedge node_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			dat_o <= '0;
		end else begin
			ack_o <= take;
			err_o <= rsp_vld_i & ~rsp_hit_i; // unmapped address
			dat_o <= take ? rsp_dat_i : '0; // bus idles at zero
		end
	end

endmodule

//--- rtl/io_top.sv
module io_top (
	input logic node_clk,
	input logic rst,
	input logic stb_i,
	input logic we_i,
	input io_pkg::bus_sel_t sel_i,
	input io_pkg::bus_adr_t adr_i,
	input io_pkg::bus_dat_t dat_i,
	output logic ack_o,
	output logic err_o,
	output io_pkg::bus_dat_t dat_o,
	output logic [7:0] leds_o,
	output io_pkg::node_mask_t node_rst_o,
	output logic tick_irq_o
);

	import io_pkg::*;

	// decode -> devices
	logic req_vld;
	dev_sel_t req_dev;
	logic req_we;
	bus_sel_t req_sel;
	logic [5:0] req_word;
	bus_dat_t req_dat;

	// devices -> respond
	logic rsp_vld;
	logic rsp_hit;
	bus_dat_t rsp_dat;

	// --------------------------------------------------
	// three stage pipe
	// --------------------------------------------------

	io_decode u_decode (
		.node_clk (node_clk),
		.rst (rst),
		.stb_i (stb_i),
		.we_i (we_i),
		.sel_i (sel_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.req_vld_o (req_vld),
		.req_dev_o (req_dev),
		.req_we_o (req_we),
		.req_sel_o (req_sel),
		.req_word_o (req_word),
		.req_dat_o (req_dat)
	);

	io_devices u_devices (
		.node_clk (node_clk),
		.rst (rst),
		.req_vld_i (req_vld),
		.req_dev_i (req_dev),
		.req_we_i (req_we),
		.req_sel_i (req_sel),
		.req_word_i (req_word),
		.req_dat_i (req_dat),
		.rsp_vld_o (rsp_vld),
		.rsp_hit_o (rsp_hit),
		.rsp_dat_o (rsp_dat),
		.leds_o (leds_o),
		.node_rst_o (node_rst_o)
	);

	io_respond u_respond (
		.node_clk (node_clk),
		.rst (rst),
		.rsp_vld_i (rsp_vld),
		.rsp_hit_i (rsp_hit),
		.rsp_dat_i (rsp_dat),
		.ack_o (ack_o),
		.err_o (err_o),
		.dat_o (dat_o)
	);

	// runs beside the pipe
	tick_timer u_tick_timer (
		.node_clk (node_clk),
		.rst (rst),
		.tick_irq_o (tick_irq_o)
	);

endmodule

//--- sim/tb_clock.sv
module tb_clock #(
	parameter int PERIOD_NS = 40
) (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_o = 1'b0;
	end

	// free-running at 50 % duty
	always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- sim/io_assert.sv
module io_assert (
	input logic node_clk,
	input logic rst,
	input logic ack_i,
	input logic err_i,
	input io_pkg::bus_dat_t dat_i
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0; // read by the testbench top

	// --------------------------------------------------
	// reply rules
	// --------------------------------------------------

	a_ack_err_excl: assert property (@(posedge node_clk) disable iff (rst)
		!(ack_i && err_i))
	else begin
		fail_cnt++;
		$error("ack_o and err_o high in the same cycle");
	end

	a_ack_pulse: assert property (@(posedge node_clk) disable iff (rst)
		ack_i |=> !ack_i)
	else begin
		fail_cnt++;
		$error("ack_o held high for more than one cycle");
	end

	a_err_pulse: assert property (@(posedge node_clk) disable iff (rst)
		err_i |=> !err_i)
	else begin
		fail_cnt++;
		$error("err_o held high for more than one cycle");
	end

	// read data only with ack
	a_dat_idle: assert property (@(posedge node_clk) disable iff (rst)
		!ack_i |-> (dat_i == '0))
	else begin
		fail_cnt++;
		$error("dat_o not zero while ack_o is low");
	end

endmodule

bind io_top io_assert i_assert (
	.node_clk (node_clk),
	.rst (rst),
	.ack_i (ack_o),
	.err_i (err_o),
	.dat_i (dat_o)
);

//--- sim/io_tb.sv
`include "io_settings.svh"

module io_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import io_pkg::*;

	localparam int NUM_ACC = 18;
	localparam int ACC_TIMEOUT = 20; // cycles per access
	localparam int RST_TIMEOUT = 4 * `RST_HOLD_CYCLES;
	localparam int TICK_TIMEOUT = 5 * `TICK_PERIOD;
	localparam int ACK_EDGES = 3;    // edges from the drive edge to the visible reply

	logic node_clk;
	logic rst;
	logic stb;
	logic we;
	bus_sel_t sel;
	bus_adr_t adr;
	bus_dat_t dat;
	logic ack;
	logic err;
	bus_dat_t dat_rd;
	logic [7:0] leds;
	node_mask_t node_rst;
	logic tick_irq;

	int mismatches;
	int timeouts;
	int n_acc;

	// --------------------------------------------------
	// access table with one row per bus access
	// --------------------------------------------------

	logic tbl_we [NUM_ACC];
	bus_adr_t tbl_adr [NUM_ACC];
	bus_sel_t tbl_sel [NUM_ACC];
	bus_dat_t tbl_dat [NUM_ACC];
	bus_dat_t tbl_exp [NUM_ACC];    // expected dat_o with the reply
	logic tbl_err [NUM_ACC];        // expect err_o instead of ack_o
	logic [7:0] tbl_leds [NUM_ACC];
	node_mask_t tbl_nrst [NUM_ACC];

	tb_clock #(.PERIOD_NS(40)) i_clock (.clk_o(node_clk));

	io_top i_dut (
		.node_clk (node_clk),
		.rst (rst),
		.stb_i (stb),
		.we_i (we),
		.sel_i (sel),
		.adr_i (adr),
		.dat_i (dat),
		.ack_o (ack),
		.err_o (err),
		.dat_o (dat_rd),
		.leds_o (leds),
		.node_rst_o (node_rst),
		.tick_irq_o (tick_irq)
	);

	function automatic bus_dat_t merge_bytes(input bus_dat_t old_w, input bus_dat_t new_w,
		input bus_sel_t be);
		bus_dat_t res;
		int b;
		res = old_w;
		for (b = 0; b < 4; b++) begin
			if (be[b])
				res[b*8 +: 8] = new_w[b*8 +: 8];
		end
		return res;
	endfunction

	task automatic add_entry(input logic w, input bus_adr_t a, input bus_sel_t s,
		input bus_dat_t d, input bus_dat_t e, input logic er, input node_mask_t nr);
		tbl_we[n_acc] = w;
		tbl_adr[n_acc] = a;
		tbl_sel[n_acc] = s;
		tbl_dat[n_acc] = d;
		tbl_exp[n_acc] = e;
		tbl_err[n_acc] = er;
		tbl_leds[n_acc] = 8'hA5; // led write is the first row
		tbl_nrst[n_acc] = nr;
		n_acc++;
	endtask

	task automatic build_table();
		int words [4];
		bus_sel_t part_sel [4];
		bus_dat_t model [4];
		bus_dat_t rnd;
		int k;
		words = '{0, 5, 17, 63};
		part_sel = '{4'b0101, 4'b1010, 4'b0011, 4'b1100};
		n_acc = 0;
		add_entry(1'b1, 32'hFD0F_FF00, 4'hF, 32'h1234_56A5, '0, 1'b0, '0);
		add_entry(1'b0, 32'hFD0F_FF00, 4'hF, '0, 32'h0000_00A5, 1'b0, '0);
		for (k = 0; k < 4; k++) begin
			rnd = $urandom;
			model[k] = rnd;
			add_entry(1'b1, 32'h0010_0000 + words[k] * 4, 4'hF, rnd, '0, 1'b0, '0);
		end
		for (k = 0; k < 4; k++) begin
			rnd = $urandom;
			model[k] = merge_bytes(model[k], rnd, part_sel[k]);
			add_entry(1'b1, 32'h0010_0000 + words[k] * 4, part_sel[k], rnd, '0, 1'b0, '0);
		end
		// reads through another address of the same region
		for (k = 0; k < 4; k++)
			add_entry(1'b0, 32'h001A_B300 + words[k] * 4, 4'hF, '0, model[k], 1'b0, '0);
		add_entry(1'b0, 32'h8000_0000, 4'hF, '0, '0, 1'b1, '0);
		add_entry(1'b1, 32'hFD0F_FE10, 4'hF, 32'hDEAD_BEEF, '0, 1'b1, '0);
		add_entry(1'b1, 32'hFD0F_FC00, 4'hF, 32'h0000_000C, '0, 1'b0, 8'h0C);
		add_entry(1'b0, 32'hFD0F_FC00, 4'hF, '0, 32'h0000_000C, 1'b0, 8'h0C);
	endtask

	// --------------------------------------------------
	// bus access and waits
	// --------------------------------------------------

	task automatic run_access(input int idx);
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		@(posedge node_clk);
		stb <= 1'b1;
		we <= tbl_we[idx];
		sel <= tbl_sel[idx];
		adr <= tbl_adr[idx];
		dat <= tbl_dat[idx];
		while (!done && n < ACC_TIMEOUT) begin
			@(posedge node_clk);
			n++;
			@(negedge node_clk);
			if (ack || err)
				done = 1'b1;
		end
		if (!done) begin
			timeouts++;
			$display("access %0d to %h got neither ack_o nor err_o", idx, tbl_adr[idx]);
		end else begin
			if (n != ACK_EDGES) begin
				mismatches++;
				$display("Mismatch at %0t: access %0d replied after %0d edges, expected %0d",
					$time, idx, n, ACK_EDGES);
			end
			if (err != tbl_err[idx] || ack == tbl_err[idx]) begin
				mismatches++;
				$display("Mismatch at %0t: access %0d ack_o %b err_o %b, expected err %b",
					$time, idx, ack, err, tbl_err[idx]);
			end
			if (dat_rd != tbl_exp[idx]) begin
				mismatches++;
				$display("Mismatch at %0t: access %0d dat_o %h, expected %h",
					$time, idx, dat_rd, tbl_exp[idx]);
			end
			if (leds != tbl_leds[idx] || node_rst != tbl_nrst[idx]) begin
				mismatches++;
				$display("Mismatch at %0t: access %0d leds_o %h node_rst_o %h, expected %h %h",
					$time, idx, leds, node_rst, tbl_leds[idx], tbl_nrst[idx]);
			end
		end
		@(posedge node_clk);
		stb <= 1'b0; // low for at least one edge before the next request
		we <= 1'b0;
	endtask

	task automatic wait_node_rst_clear(input string what);
		int n;
		n = 0;
		while (node_rst != '0 && n < RST_TIMEOUT) begin
			@(negedge node_clk);
			n++;
		end
		if (node_rst != '0) begin
			timeouts++;
			$display("node_rst_o did not clear %s", what);
		end
	endtask

	task automatic check_tick();
		int cyc;
		int rise_cyc;
		int rises;
		logic prev;
		cyc = 0;
		rise_cyc = 0;
		rises = 0;
		@(negedge node_clk);
		prev = tick_irq;
		while (rises < 4 && cyc < TICK_TIMEOUT) begin
			@(negedge node_clk);
			cyc++;
			if (tick_irq && !prev) begin
				if (rises > 0 && cyc - rise_cyc != `TICK_PERIOD) begin
					mismatches++;
					$display("Mismatch at %0t: tick spacing %0d, expected %0d",
						$time, cyc - rise_cyc, `TICK_PERIOD);
				end
				rise_cyc = cyc;
				rises++;
			end else if (!tick_irq && prev && rises > 0) begin
				if (cyc - rise_cyc != `TICK_OFF - `TICK_ON) begin
					mismatches++;
					$display("Mismatch at %0t: tick high for %0d, expected %0d",
						$time, cyc - rise_cyc, `TICK_OFF - `TICK_ON);
				end
			end
			prev = tick_irq;
		end
		if (rises < 4) begin
			timeouts++;
			$display("tick_irq_o stopped toggling after %0d rising edges", rises);
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		mismatches = 0;
		timeouts = 0;
		rst = 1'b1;
		stb = 1'b0;
		we = 1'b0;
		sel = '0;
		adr = '0;
		dat = '0;
		void'($urandom(32'hec64));
		build_table();
		repeat (10) @(posedge node_clk);
		rst <= 1'b0;
		@(negedge node_clk);
		if (node_rst != '1 || leds != 8'h00 || ack || err) begin
			mismatches++;
			$display("Mismatch at %0t: after reset node_rst_o %h leds_o %h ack %b err %b",
				$time, node_rst, leds, ack, err);
		end
		wait_node_rst_clear("after system reset");
		for (int i = 0; i < n_acc; i++)
			run_access(i);
		wait_node_rst_clear("after the reset page write");
		check_tick();
		$display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, i_dut.i_assert.fail_cnt);
		if (mismatches == 0 && timeouts == 0 && i_dut.i_assert.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- list.f
+incdir+include
rtl/io_pkg.sv
rtl/node_reset_ctrl.sv
rtl/tick_timer.sv
rtl/io_decode.sv
rtl/io_devices.sv
rtl/io_respond.sv
rtl/io_top.sv
sim/tb_clock.sv
sim/io_assert.sv
sim/io_tb.sv

//--- Bender.yml
package:
  name: io_subsys

export_include_dirs:
  - include

sources:
  - files:
      - rtl/io_pkg.sv
      - rtl/node_reset_ctrl.sv
      - rtl/tick_timer.sv
      - rtl/io_decode.sv
      - rtl/io_devices.sv
      - rtl/io_respond.sv
      - rtl/io_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/io_assert.sv
      - sim/io_tb.sv
